// ==== source/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Bank geometry
`define CACHE_WAYS       4
`define CACHE_SETS       4
`define CACHE_LINE_BYTES 16

// Tag covers address bits 14:7
`define CACHE_TAG_BITS   8

`endif

// ==== source/cache_bank_pkg.sv ====
`default_nettype none

`include "cache_params.svh"

package cache_bank_pkg;

  localparam int INDEX_BITS  = $clog2(`CACHE_SETS);
  localparam int OFFSET_BITS = $clog2(`CACHE_LINE_BYTES);

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cache_op_e;

  // Bit 4 sits between index and offset and is not decoded
  typedef struct packed {
    logic [`CACHE_TAG_BITS-1:0] tag;
    logic [INDEX_BITS-1:0]      index;
    logic                       spare;
    logic [OFFSET_BITS-1:0]     offset;
  } cache_addr_t;

  typedef logic [`CACHE_LINE_BYTES*8-1:0] cache_line_t;
  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

endpackage

`default_nettype wire

// ==== source/cache_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// Decode stage to lookup stage
interface dec_lookup_if;
  import cache_bank_pkg::*;

  logic        valid;
  cache_op_e   op;
  cache_addr_t addr;
  cache_line_t wdata;
  cache_line_t wmask;
  // Lookup keeps decode frozen during a miss
  logic        hold;

  modport source (output valid, op, addr, wdata, wmask, input hold);
  modport sink   (input valid, op, addr, wdata, wmask, output hold);
endinterface

// Lookup stage to data stage
interface lookup_data_if;
  import cache_bank_pkg::*;

  // Hit access
  logic        valid;
  cache_op_e   op;
  cache_addr_t addr;
  index_t      index;
  way_t        way;
  cache_line_t wdata;
  cache_line_t wmask;
  // Line install and victim readout share index
  logic        fill_valid;
  cache_line_t fill_line;
  way_t        fill_way;
  logic        victim_read;
  cache_line_t victim_line;

  modport source (
    output valid, op, addr, index, way, wdata, wmask,
    output fill_valid, fill_line, fill_way, victim_read,
    input  victim_line
  );
  modport sink (
    input  valid, op, addr, index, way, wdata, wmask,
    input  fill_valid, fill_line, fill_way, victim_read,
    output victim_line
  );
endinterface

`default_nettype wire

// ==== source/cache_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_decode (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     valid_in,
  input  cache_bank_pkg::cache_op_e   op,
  input  cache_bank_pkg::cache_addr_t p_address,
  input  cache_bank_pkg::cache_line_t data,
  input  cache_bank_pkg::cache_line_t mask,
  output logic                     stall,
  output logic                     accept,
  dec_lookup_if.source             dec
);
  import cache_bank_pkg::*;

  logic        valid_q;
  cache_op_e   op_q;
  cache_addr_t addr_q;
  cache_line_t data_q;
  cache_line_t mask_q;

  assign stall  = dec.hold;
  assign accept = valid_in && !dec.hold;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (!dec.hold) begin
      valid_q <= accept;
    end
  end

  // Payload only moves when a new request is taken
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q   <= op;
      addr_q <= p_address;
      data_q <= data;
      mask_q <= mask;
    end
  end

  assign dec.valid = valid_q;
  assign dec.op    = op_q;
  assign dec.addr  = addr_q;
  assign dec.wdata = data_q;
  assign dec.wmask = mask_q;

  // Lookup only freezes a stage that holds a request
  hold_has_request: assert property (@(posedge clk) disable iff (rst)
    dec.hold |-> valid_q);

endmodule

`default_nettype wire

// ==== source/cache_lookup.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_lookup (
  input  logic                        clk,
  input  logic                        rst,
  dec_lookup_if.sink                  dec,
  lookup_data_if.source               dat,
  output logic                        fill_req,
  output cache_bank_pkg::cache_addr_t fill_address,
  input  logic                        fill_valid,
  input  cache_bank_pkg::cache_line_t fill_data,
  output logic                        wb_valid,
  output cache_bank_pkg::cache_addr_t wb_address
);
  import cache_bank_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_WB, S_REQ, S_WAIT, S_REPLAY} state_e;

  logic [`CACHE_TAG_BITS-1:0] tag_q [`CACHE_SETS][`CACHE_WAYS];
  logic [`CACHE_WAYS-1:0]     valid_q [`CACHE_SETS];
  logic [`CACHE_WAYS-1:0]     dirty_q [`CACHE_SETS];
  // Age 0 is most recent, all ones is the victim
  way_t                       age_q [`CACHE_SETS][`CACHE_WAYS];

  state_e                 state_q;
  logic                   hit_q;
  cache_op_e              op_q;
  cache_addr_t            addr_q;
  cache_line_t            wdata_q;
  cache_line_t            wmask_q;
  way_t                   way_q;
  way_t                   victim_q;
  index_t                 set_idx;
  logic [`CACHE_WAYS-1:0] hit_vec;
  way_t                   hit_way;
  way_t                   victim_way;
  logic                   active;
  logic                   lookup_hit;
  logic                   lookup_miss;
  logic                   fill_we;

  assign set_idx = dec.addr.index;

  always_comb begin
    hit_way    = '0;
    victim_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit_vec[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == dec.addr.tag);
      if (hit_vec[w]) hit_way = way_t'(w);
      if (age_q[set_idx][w] == '1) victim_way = way_t'(w);
    end
  end

  // Replay reuses the normal compare path
  assign active      = (state_q == S_IDLE) || (state_q == S_REPLAY);
  assign lookup_hit  = active && dec.valid && (|hit_vec);
  assign lookup_miss = active && dec.valid && !(|hit_vec);
  assign fill_we     = (state_q == S_WAIT) && fill_valid;
  assign dec.hold    = lookup_miss || (state_q == S_WB) || (state_q == S_REQ) ||
                       (state_q == S_WAIT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      hit_q   <= 1'b0;
      for (int s = 0; s < `CACHE_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        for (int w = 0; w < `CACHE_WAYS; w++) age_q[s][w] <= way_t'(w);
      end
    end else begin
      hit_q <= lookup_hit;
      case (state_q)
        S_IDLE, S_REPLAY: begin
          if (lookup_miss)
            state_q <= (valid_q[set_idx][victim_way] && dirty_q[set_idx][victim_way]) ?
                       S_WB : S_REQ;
          else
            state_q <= S_IDLE;
        end
        S_WB:    state_q <= S_REQ;
        S_REQ:   state_q <= S_WAIT;
        S_WAIT:  if (fill_valid) state_q <= S_REPLAY;
        default: state_q <= S_IDLE;
      endcase
      if (lookup_hit) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          if (way_t'(w) == hit_way)
            age_q[set_idx][w] <= '0;
          else if (age_q[set_idx][w] < age_q[set_idx][hit_way])
            age_q[set_idx][w] <= age_q[set_idx][w] + 1'b1;
        end
        if (dec.op == OP_WRITE) dirty_q[set_idx][hit_way] <= 1'b1;
      end
      if (fill_we) begin
        valid_q[addr_q.index][victim_q] <= 1'b1;
        dirty_q[addr_q.index][victim_q] <= 1'b0;
      end
    end
  end

  // Request payload, captured every compare cycle
  always_ff @(posedge clk) begin
    if (active) begin
      op_q    <= dec.op;
      addr_q  <= dec.addr;
      wdata_q <= dec.wdata;
      wmask_q <= dec.wmask;
      way_q   <= hit_way;
    end
    if (lookup_miss) victim_q <= victim_way;
    if (fill_we) tag_q[addr_q.index][victim_q] <= addr_q.tag;
  end

  assign fill_req     = (state_q == S_REQ);
  assign fill_address = '{tag: addr_q.tag, index: addr_q.index, spare: 1'b0, offset: '0};
  assign wb_valid     = (state_q == S_WB);
  assign wb_address   = '{tag: tag_q[addr_q.index][victim_q], index: addr_q.index,
                          spare: 1'b0, offset: '0};

  assign dat.valid       = hit_q;
  assign dat.op          = op_q;
  assign dat.addr        = addr_q;
  assign dat.index       = addr_q.index;
  assign dat.way         = way_q;
  assign dat.wdata       = wdata_q;
  assign dat.wmask       = wmask_q;
  assign dat.fill_valid  = fill_we;
  assign dat.fill_line   = fill_data;
  assign dat.fill_way    = victim_q;
  assign dat.victim_read = (state_q == S_WB);

  single_way_hit: assert property (@(posedge clk) disable iff (rst)
    dec.valid |-> $onehot0(hit_vec));
  fill_only_when_waiting: assert property (@(posedge clk) disable iff (rst)
    fill_valid |-> state_q == S_WAIT);
  // Installed line must satisfy the held request
  replay_hits: assert property (@(posedge clk) disable iff (rst)
    state_q == S_REPLAY |-> lookup_hit);

endmodule

`default_nettype wire

// ==== source/cache_data.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cache_params.svh"

module cache_data (
  input  logic                        clk,
  input  logic                        rst,
  lookup_data_if.sink                 dat,
  output logic                        ex_valid,
  output cache_bank_pkg::cache_line_t ex_data,
  output cache_bank_pkg::cache_addr_t ex_address,
  output cache_bank_pkg::cache_line_t wb_data
);
  import cache_bank_pkg::*;

  cache_line_t mem_q [`CACHE_SETS][`CACHE_WAYS];
  cache_line_t rd_line;
  cache_line_t merged;

  // Byte merge of write data over the stored line
  always_comb begin
    rd_line = mem_q[dat.index][dat.way];
    for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
      merged[b*8 +: 8] = (dat.wdata[b*8 +: 8] & dat.wmask[b*8 +: 8]) |
                         (rd_line[b*8 +: 8] & ~dat.wmask[b*8 +: 8]);
    end
  end

  // Result goes out in the same cycle as the array read
  assign ex_valid   = dat.valid;
  assign ex_data    = (dat.op == OP_WRITE) ? merged : rd_line;
  assign ex_address = dat.addr;

  // Victim way is the same way the fill will replace
  assign dat.victim_line = dat.victim_read ? mem_q[dat.index][dat.fill_way] : '0;
  assign wb_data         = dat.victim_line;

  always_ff @(posedge clk) begin
    if (dat.fill_valid) begin
      mem_q[dat.index][dat.fill_way] <= dat.fill_line;
    end else if (dat.valid && (dat.op == OP_WRITE)) begin
      mem_q[dat.index][dat.way] <= merged;
    end
  end

  // Fills only arrive once the pipe has drained behind the miss
  no_fill_during_hit: assert property (@(posedge clk) disable iff (rst)
    dat.fill_valid |-> !dat.valid);

  // Writeback read never overlaps a line install
  no_victim_during_fill: assert property (@(posedge clk) disable iff (rst)
    dat.victim_read |-> !dat.fill_valid ##1 !dat.fill_valid);

endmodule

`default_nettype wire

// ==== source/cache_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_bank (
  input  logic                                         clk,
  input  logic                                         rst,
  // Requester side
  input  logic                                         valid_in,
  input  cache_bank_pkg::cache_op_e                    op,
  input  logic [$bits(cache_bank_pkg::cache_addr_t)-1:0] p_address,
  input  cache_bank_pkg::cache_line_t                  data,
  input  cache_bank_pkg::cache_line_t                  mask,
  output logic                                         accept,
  output logic                                         stall,
  // Miss side
  output logic                                         fill_req,
  output logic [$bits(cache_bank_pkg::cache_addr_t)-1:0] fill_address,
  input  logic                                         fill_valid,
  input  cache_bank_pkg::cache_line_t                  fill_data,
  output logic                                         wb_valid,
  output logic [$bits(cache_bank_pkg::cache_addr_t)-1:0] wb_address,
  output cache_bank_pkg::cache_line_t                  wb_data,
  // Result side
  output logic                                         ex_valid,
  output cache_bank_pkg::cache_line_t                  ex_data,
  output logic [$bits(cache_bank_pkg::cache_addr_t)-1:0] ex_address
);

  dec_lookup_if  dl_if ();
  lookup_data_if ld_if ();

  cache_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (valid_in),
    .op        (op),
    .p_address (p_address),
    .data      (data),
    .mask      (mask),
    .stall     (stall),
    .accept    (accept),
    .dec       (dl_if.source)
  );

  cache_lookup u_lookup (
    .clk          (clk),
    .rst          (rst),
    .dec          (dl_if.sink),
    .dat          (ld_if.source),
    .fill_req     (fill_req),
    .fill_address (fill_address),
    .fill_valid   (fill_valid),
    .fill_data    (fill_data),
    .wb_valid     (wb_valid),
    .wb_address   (wb_address)
  );

  cache_data u_data (
    .clk        (clk),
    .rst        (rst),
    .dat        (ld_if.sink),
    .ex_valid   (ex_valid),
    .ex_data    (ex_data),
    .ex_address (ex_address),
    .wb_data    (wb_data)
  );

endmodule

`default_nettype wire

// ==== sim/cache_bank_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module cache_bank_tb;
  import cache_bank_pkg::*;

  localparam int MAX_PAT    = 64;
  localparam int NUM_RANDOM = 40;

  typedef struct packed {
    logic        is_write;
    logic [14:0] addr;
    cache_line_t wdata;
    logic [15:0] bmask;
    cache_line_t file_exp;
    logic        use_file;
    int          acc_cycle;
  } req_t;

  logic        clk;
  logic        rst;
  logic        valid_in;
  cache_op_e   op;
  logic [14:0] p_address;
  cache_line_t data;
  cache_line_t mask;
  logic        accept;
  logic        stall;
  logic        fill_req;
  logic [14:0] fill_address;
  logic        fill_valid;
  cache_line_t fill_data;
  logic        wb_valid;
  logic [14:0] wb_address;
  cache_line_t wb_data;
  logic        ex_valid;
  cache_line_t ex_data;
  logic [14:0] ex_address;

  req_t        exp_q [$];
  req_t        pat [MAX_PAT];
  // Requester view and backing memory keyed by address bits 14:5
  cache_line_t model_line [logic [9:0]];
  cache_line_t mem_line [logic [9:0]];
  bit          written [logic [9:0]];
  int          n_pat = 0;
  bit          loaded = 1'b0;
  int          cycle = 0;
  int          last_stall = 0;
  int          last_wb = 0;
  int          last_fill = 0;
  bit          fill_pending = 1'b0;
  logic [31:0] stim_rng = 32'h7df7;
  logic [31:0] delay_rng = 32'h7df7;

  cache_bank DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Byte i of an untouched line is the line address low byte XOR i
  function automatic cache_line_t init_line(input logic [9:0] key);
    cache_line_t l;
    for (int i = 0; i < 16; i++) l[i*8 +: 8] = key[7:0] ^ 8'(i);
    return l;
  endfunction

  function automatic cache_line_t expand_mask(input logic [15:0] bmask);
    cache_line_t m;
    for (int b = 0; b < 16; b++) m[b*8 +: 8] = {8{bmask[b]}};
    return m;
  endfunction

  function automatic cache_line_t merge_line(input cache_line_t old_line,
                                             input cache_line_t wdata,
                                             input logic [15:0] bmask);
    cache_line_t res;
    res = old_line;
    for (int b = 0; b < 16; b++) begin
      if (bmask[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic cache_line_t model_read(input logic [9:0] key);
    if (model_line.exists(key)) return model_line[key];
    return init_line(key);
  endfunction

  function automatic cache_line_t backing_read(input logic [9:0] key);
    if (mem_line.exists(key)) return mem_line[key];
    return init_line(key);
  endfunction

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] time %0t: %s mismatch, got %h expected %h", $time, what, actual,
               expected);
      $display("Simulation failed");
      $fatal(1, "check failed");
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          cnt;
    string       text;
    logic [3:0]  op_v;
    logic [15:0] addr_v;
    cache_line_t data_v;
    logic [15:0] mask_v;
    cache_line_t exp_v;
    fd = $fopen("sim/cache_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file sim/cache_patterns.txt");
      $display("Simulation failed");
      $fatal(1, "missing pattern file");
    end else begin
      while ($fgets(text, fd) > 0) begin
        if (text.len() > 1 && text.getc(0) != "#" && n_pat < MAX_PAT) begin
          cnt = $sscanf(text, "%h %h %h %h %h", op_v, addr_v, data_v, mask_v, exp_v);
          if (cnt == 5) begin
            pat[n_pat].is_write = op_v[0];
            pat[n_pat].addr     = addr_v[14:0];
            pat[n_pat].wdata    = data_v;
            pat[n_pat].bmask    = mask_v;
            pat[n_pat].file_exp = exp_v;
            pat[n_pat].use_file = 1'b1;
            n_pat++;
          end
        end
      end
      $fclose(fd);
      loaded = 1'b1;
    end
  endtask

  // Drive at +2 ns and keep the request up until accept is seen
  task automatic send_request(input req_t r);
    req_t q;
    q         = r;
    valid_in  = 1'b1;
    op        = cache_op_e'(r.is_write);
    p_address = r.addr;
    data      = r.wdata;
    mask      = expand_mask(r.bmask);
    @(negedge clk);
    while (!accept) @(negedge clk);
    q.acc_cycle = cycle;
    exp_q.push_back(q);
    @(posedge clk);
    #2;
    valid_in = 1'b0;
  endtask

  task automatic check_result();
    req_t        r;
    logic [9:0]  key;
    cache_line_t l;
    if (exp_q.size() == 0) begin
      $display("A result came out at time %0t with no request outstanding", $time);
      $display("Simulation failed");
      $fatal(1, "unexpected result");
    end else begin
      r   = exp_q.pop_front();
      key = r.addr[14:5];
      l   = model_read(key);
      if (r.is_write) begin
        l = merge_line(l, r.wdata, r.bmask);
        model_line[key] = l;
        written[key] = 1'b1;
      end
      if (r.use_file) l = r.file_exp;
      check_value(ex_data, l, "result data");
      check_value(128'(ex_address), 128'(r.addr), "result address");
      // No stall in flight means a plain hit
      if (last_stall <= r.acc_cycle)
        check_value(128'(cycle - r.acc_cycle), 128'd2, "hit latency");
    end
  endtask

  task automatic take_writeback();
    logic [9:0] key;
    key = wb_address[14:5];
    check_value(128'(wb_address[4:0]), 128'd0, "writeback address low bits");
    check_value(128'(written.exists(key)), 128'd1, "writeback of an unwritten line");
    check_value(wb_data, model_read(key), "writeback data");
    mem_line[key] = wb_data;
    last_wb = cycle;
  endtask

  task automatic check_fill();
    if (exp_q.size() == 0) begin
      $display("A fill request came out at time %0t with no request outstanding", $time);
      $display("Simulation failed");
      $fatal(1, "unexpected fill request");
    end else begin
      check_value(128'(fill_address), 128'({exp_q[0].addr[14:5], 5'b0}), "fill address");
      if (last_wb > last_fill)
        check_value(128'(cycle - last_wb), 128'd1, "writeback to fill spacing");
      last_fill = cycle;
    end
  endtask

  always @(negedge clk) begin
    if (rst) begin
      check_value(128'({accept, fill_req, wb_valid, ex_valid}), 128'd0, "outputs in reset");
    end else begin
      if (ex_valid) check_result();
      if (wb_valid) take_writeback();
      if (fill_req) check_fill();
      // Miss window runs from the writeback through the fill answer
      if (wb_valid || fill_req || fill_pending)
        check_value(128'(stall), 128'd1, "stall during miss");
      if (fill_req) fill_pending = 1'b1;
      if (fill_valid) fill_pending = 1'b0;
      if (stall) last_stall = cycle;
    end
  end

  // Fill responder with a random 1 to 8 cycle delay
  initial begin
    logic [9:0] key;
    int         delay;
    forever begin
      @(negedge clk);
      if (fill_req) begin
        key       = fill_address[14:5];
        delay_rng = xorshift(delay_rng);
        delay     = int'(delay_rng[2:0]) + 1;
        repeat (delay) @(posedge clk);
        #2;
        fill_data  = backing_read(key);
        fill_valid = 1'b1;
        @(posedge clk);
        #2;
        fill_valid = 1'b0;
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (16 + (n_pat + NUM_RANDOM) * 200) @(posedge clk);
    $display("Watchdog expired: the requests did not all complete in time");
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  initial begin
    req_t r;
    rst        = 1'b1;
    valid_in   = 1'b0;
    op         = OP_READ;
    p_address  = '0;
    data       = '0;
    mask       = '0;
    fill_valid = 1'b0;
    fill_data  = '0;
    load_patterns();
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 0; i < n_pat; i++) send_request(pat[i]);
    // Random phase over eight tags to force evictions
    for (int i = 0; i < NUM_RANDOM; i++) begin
      stim_rng   = xorshift(stim_rng);
      r.addr     = {5'b0, stim_rng[2:0], stim_rng[4:3], stim_rng[5], stim_rng[9:6]};
      r.is_write = stim_rng[10];
      r.bmask    = stim_rng[31:16];
      for (int w = 0; w < 4; w++) begin
        stim_rng = xorshift(stim_rng);
        r.wdata[w*32 +: 32] = stim_rng;
      end
      r.file_exp = '0;
      r.use_file = 1'b0;
      r.acc_cycle = 0;
      send_request(r);
    end
    while (exp_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/cache_bank_pkg.sv
source/cache_if.sv
source/cache_decode.sv
source/cache_lookup.sv
source/cache_data.sv
source/cache_bank.sv
sim/cache_bank_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module cache_bank_tb -Mdir obj_dir -o cache_bank_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/cache_bank_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi
exit 0

// ==== sim/cache_patterns.txt ====
# op (0 read, 1 write), address, write data, byte mask (bit i = byte i), expected line
# All columns hex, byte 0 is the rightmost pair
0 00a0 00000000000000000000000000000000 0000 0a0b08090e0f0c0d0203000106070405
0 00a0 00000000000000000000000000000000 0000 0a0b08090e0f0c0d0203000106070405
1 00a0 ffeeddccbbaa99887766554433221100 000f 0a0b08090e0f0c0d0203000133221100
0 00a0 00000000000000000000000000000000 0000 0a0b08090e0f0c0d0203000133221100
0 0120 00000000000000000000000000000000 0000 06070405020300010e0f0c0d0a0b0809
0 01a0 00000000000000000000000000000000 0000 02030001060704050a0b08090e0f0c0d
0 0220 00000000000000000000000000000000 0000 1e1f1c1d1a1b18191617141512131011
0 02a0 00000000000000000000000000000000 0000 1a1b18191e1f1c1d1213101116171415
0 00a0 00000000000000000000000000000000 0000 0a0b08090e0f0c0d0203000133221100
0 0220 00000000000000000000000000000000 0000 1e1f1c1d1a1b18191617141512131011
0 02a0 00000000000000000000000000000000 0000 1a1b18191e1f1c1d1213101116171415
0 00a0 00000000000000000000000000000000 0000 0a0b08090e0f0c0d0203000133221100
0 01a0 00000000000000000000000000000000 0000 02030001060704050a0b08090e0f0c0d
0 0800 00000000000000000000000000000000 0000 4f4e4d4c4b4a49484746454443424140
0 01a0 00000000000000000000000000000000 0000 02030001060704050a0b08090e0f0c0d
1 0800 ffeeddccbbaa99887766554433221100 8001 ff4e4d4c4b4a49484746454443424100
0 0800 00000000000000000000000000000000 0000 ff4e4d4c4b4a49484746454443424100
1 0880 ffeeddccbbaa99887766554433221100 0ff0 4b4a4948bbaa99887766554447464544
0 0880 00000000000000000000000000000000 0000 4b4a4948bbaa99887766554447464544
0 0810 00000000000000000000000000000000 0000 ff4e4d4c4b4a49484746454443424100
